//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int ADDR_W         = 16;                    // Word address width
	localparam int WORD_W         = 16;                    // Data word width
	localparam int WORDS_PER_LINE = 4;                     // Words in one cache line
	localparam int LINE_W         = WORD_W * WORDS_PER_LINE; // 64 bit line
	localparam int OFFSET_W       = 2;                     // Word offset inside a line
	localparam int INDEX_W        = 6;                     // 64 lines per cache
	localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W; // 8 bit tag
	localparam int MEM_ADDR_W     = TAG_W + INDEX_W;       // Line address into memory

	// One cache line, seen either whole or as its four words
	typedef union packed {
		logic [LINE_W-1:0]                     flat;  // Whole line
		logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words; // Word 0 sits in the low bits
	} cache_line_u;

endpackage

`default_nettype wire

//--- rtl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache import cache_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,
	input  wire  [ADDR_W-1:0] i_addr,  // Fetch address
	input  wire               i_we,    // Line fill from controller
	input  wire  [LINE_W-1:0] i_data,  // Fill line
	output logic              o_hit,
	output logic [WORD_W-1:0] o_word
);

	localparam int NUM_LINES = 2 ** INDEX_W;

	cache_line_u      lines [NUM_LINES]; // Line storage, no reset
	logic [TAG_W-1:0] tags  [NUM_LINES]; // Stored tags
	logic [NUM_LINES-1:0] valid;         // One valid bit per line

	logic [TAG_W-1:0]    tag;
	logic [INDEX_W-1:0]  index;
	logic [OFFSET_W-1:0] offset;

	assign tag    = i_addr[ADDR_W-1 -: TAG_W];    // Upper bits
	assign index  = i_addr[OFFSET_W +: INDEX_W];  // Middle bits pick the line
	assign offset = i_addr[OFFSET_W-1:0];         // Low bits pick the word

	// Valid bits clear on reset, set on a fill
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (i_we) begin
			valid[index] <= 1'b1;
		end
	end

	// Tag and data written together on a fill
	always_ff @(posedge clk) begin
		if (i_we) begin
			tags[index]       <= tag;
			lines[index].flat <= i_data;
		end
	end

	assign o_hit  = valid[index] && (tags[index] == tag); // Valid and matching tag
	assign o_word = lines[index].words[offset];           // Word select through the union

endmodule

`default_nettype wire

//--- rtl/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache import cache_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,
	input  wire  [ADDR_W-1:0] i_addr,  // Data address
	input  wire               i_we,    // Line write from controller
	input  wire  [LINE_W-1:0] i_data,  // Refill or merged line
	input  wire               i_dirty, // Dirty value stored with the write
	output logic              o_hit,
	output logic              o_dirty, // Indexed line holds modified data
	output logic [TAG_W-1:0]  o_tag,   // Victim tag for write-back
	output logic [LINE_W-1:0] o_line,  // Victim line for write-back
	output logic [WORD_W-1:0] o_word
);

	localparam int NUM_LINES = 2 ** INDEX_W;

	cache_line_u          lines [NUM_LINES]; // Line storage
	logic [TAG_W-1:0]     tags  [NUM_LINES];
	logic [NUM_LINES-1:0] valid;
	logic [NUM_LINES-1:0] dirty;

	logic [TAG_W-1:0]    tag;
	logic [INDEX_W-1:0]  index;
	logic [OFFSET_W-1:0] offset;

	assign tag    = i_addr[ADDR_W-1 -: TAG_W];
	assign index  = i_addr[OFFSET_W +: INDEX_W];
	assign offset = i_addr[OFFSET_W-1:0];

	// Control bits, cleared on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_we) begin
			valid[index] <= 1'b1;
			dirty[index] <= i_dirty; // Clean on a read refill, set on any write
		end
	end

	// Payload arrays
	always_ff @(posedge clk) begin
		if (i_we) begin
			tags[index]       <= tag;
			lines[index].flat <= i_data;
		end
	end

	assign o_hit   = valid[index] && (tags[index] == tag);
	assign o_dirty = valid[index] && dirty[index]; // Regardless of tag match

	// Whatever sits at the index is the eviction candidate
	assign o_tag  = tags[index];
	assign o_line = lines[index].flat;
	assign o_word = lines[index].words[offset];

endmodule

`default_nettype wire

//--- rtl/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller import cache_pkg::*; (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire  [ADDR_W-1:0]     i_i_addr,  // Fetch address
	input  wire  [ADDR_W-1:0]     i_d_addr,  // Data address
	input  wire  [WORD_W-1:0]     i_wr_data, // Store data
	input  wire                   i_i_acc,   // Fetch requested
	input  wire                   i_d_acc,   // Data access requested
	input  wire                   i_write,   // Data access is a store
	input  wire                   i_i_hit,
	input  wire                   i_d_hit,
	input  wire                   i_dirty,   // Indexed data line is dirty
	input  wire                   i_mem_rdy, // One cycle pulse from memory
	input  wire  [TAG_W-1:0]      i_d_tag,   // Victim tag
	input  wire  [LINE_W-1:0]     i_d_line,  // Current data cache line
	input  wire  [LINE_W-1:0]     i_m_line,  // Line read from memory
	output logic                  o_i_we,
	output logic [LINE_W-1:0]     o_i_data,
	output logic                  o_d_we,
	output logic [LINE_W-1:0]     o_d_data,
	output logic                  o_d_dirty,
	output logic                  o_m_re,
	output logic                  o_m_we,
	output logic [MEM_ADDR_W-1:0] o_m_addr,
	output logic [LINE_W-1:0]     o_m_data,
	output logic                  o_rdy      // Both pending accesses served
);

	localparam logic [1:0] S_IDLE   = 2'd0;
	localparam logic [1:0] S_WB     = 2'd1; // Dirty victim going out
	localparam logic [1:0] S_REFILL = 2'd2; // Waiting on the line read

	logic [1:0]            state;
	logic [1:0]            next_state;
	logic                  d_miss;
	logic                  i_miss;
	logic [OFFSET_W-1:0]   d_off;
	logic [INDEX_W-1:0]    d_idx;
	logic [MEM_ADDR_W-1:0] victim_addr;
	cache_line_u           merged;    // Line with the store word replaced

	assign d_miss      = i_d_acc & ~i_d_hit;
	assign i_miss      = i_i_acc & ~i_i_hit;
	assign d_off       = i_d_addr[OFFSET_W-1:0];
	assign d_idx       = i_d_addr[OFFSET_W +: INDEX_W];
	assign victim_addr = {i_d_tag, d_idx}; // Where the resident line came from

	// Merge base is the fresh memory line during refill, else the cached line
	always_comb begin
		merged.flat         = (state == S_REFILL) ? i_m_line : i_d_line;
		merged.words[d_off] = i_wr_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		o_i_we     = 1'b0;
		o_i_data   = i_m_line;
		o_d_we     = 1'b0;
		o_d_data   = i_m_line;
		o_d_dirty  = 1'b0;
		o_m_re     = 1'b0;
		o_m_we     = 1'b0;
		o_m_addr   = '0;
		o_m_data   = i_d_line; // Victim line is the only thing ever written out
		o_rdy      = 1'b0;

		case (state)
			S_IDLE: begin
				if (d_miss) begin // Data side goes first
					if (i_dirty) begin
						o_m_we     = 1'b1;
						o_m_addr   = victim_addr;
						next_state = S_WB;
					end else begin
						o_m_re     = 1'b1;
						o_m_addr   = i_d_addr[ADDR_W-1:OFFSET_W];
						next_state = S_REFILL;
					end
				end else if (i_miss) begin
					o_m_re     = 1'b1;
					o_m_addr   = i_i_addr[ADDR_W-1:OFFSET_W];
					next_state = S_REFILL;
				end else begin
					o_rdy = 1'b1; // Everything requested hits
					if (i_d_acc && i_write) begin // Store hit updates the line in place
						o_d_we    = 1'b1;
						o_d_data  = merged.flat;
						o_d_dirty = 1'b1;
					end
				end
			end

			S_WB: begin
				o_m_we   = 1'b1; // Hold until memory accepts
				o_m_addr = victim_addr;
				if (i_mem_rdy) begin
					next_state = S_REFILL;
				end
			end

			S_REFILL: begin
				o_m_re   = 1'b1;
				o_m_addr = d_miss ? i_d_addr[ADDR_W-1:OFFSET_W]
				                  : i_i_addr[ADDR_W-1:OFFSET_W];
				if (i_mem_rdy) begin
					if (d_miss) begin
						o_d_we    = 1'b1;
						o_d_data  = i_write ? merged.flat : i_m_line; // Allocate on store
						o_d_dirty = i_write;
					end else begin
						o_i_we = 1'b1; // Instruction fill
					end
					next_state = S_IDLE; // Access hits on the next cycle
				end
			end

			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

module unified_mem import cache_pkg::*; #(
	parameter int MEM_LATENCY = 4 // Request cycles before the ready pulse
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   i_re,   // Line read request level
	input  wire                   i_we,   // Line write request level
	input  wire  [MEM_ADDR_W-1:0] i_addr, // Line address
	input  wire  [LINE_W-1:0]     i_data, // Write-back line
	output logic                  o_rdy,  // Single cycle completion pulse
	output logic [LINE_W-1:0]     o_line  // Read line, valid with o_rdy
);

	localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

	logic [LINE_W-1:0] mem [2**MEM_ADDR_W]; // 16K lines
	logic [CNT_W-1:0]  cnt;                 // Consecutive request cycles seen
	logic              req;
	logic              done;

	assign req  = i_re | i_we;
	assign done = req && (cnt == CNT_W'(MEM_LATENCY - 1)); // Last counted cycle

	initial begin
		for (int i = 0; i < 2**MEM_ADDR_W; i++) begin
			mem[i] = '0;
		end
	end

	// Latency counter, the ready cycle itself is never counted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt   <= '0;
			o_rdy <= 1'b0;
		end else if (o_rdy) begin
			cnt   <= '0; // Next request starts from scratch
			o_rdy <= 1'b0;
		end else if (done) begin
			cnt   <= '0;
			o_rdy <= 1'b1;
		end else if (req) begin
			cnt   <= cnt + 1'b1;
		end else begin
			cnt   <= '0; // Dropped request restarts the count
		end
	end

	// Read data lands in the ready cycle
	always_ff @(posedge clk) begin
		if (done && !o_rdy) begin
			o_line <= mem[i_addr];
		end
	end

	// Write commits at the end of the ready cycle
	always_ff @(posedge clk) begin
		if (o_rdy && i_we) begin
			mem[i_addr] <= i_data;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module mem_hierarchy import cache_pkg::*; #(
	parameter int MEM_LATENCY = 4
) (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               i_i_acc,   // Fetch request level
	input  wire  [ADDR_W-1:0] i_i_addr,
	input  wire               i_d_acc,   // Data request level
	input  wire  [ADDR_W-1:0] i_d_addr,
	input  wire               i_d_write, // Store when high
	input  wire  [WORD_W-1:0] i_wr_data,
	output logic [WORD_W-1:0] o_instr,
	output logic [WORD_W-1:0] o_rd_data,
	output logic              o_rdy
);

	logic                  i_hit;
	logic                  i_we;
	logic [LINE_W-1:0]     i_data;
	logic                  d_hit;
	logic                  dirty;
	logic [TAG_W-1:0]      d_tag;
	logic [LINE_W-1:0]     d_line;
	logic                  d_we;
	logic [LINE_W-1:0]     d_data;
	logic                  d_dirt_in;
	logic                  m_re;
	logic                  m_we;
	logic [MEM_ADDR_W-1:0] m_addr;
	logic [LINE_W-1:0]     m_data;
	logic                  mem_rdy;
	logic [LINE_W-1:0]     m_line;

	icache u_icache (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_addr (i_i_addr),
		.i_we   (i_we),
		.i_data (i_data),
		.o_hit  (i_hit),
		.o_word (o_instr)
	);

	cache_controller u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_addr  (i_i_addr),
		.i_d_addr  (i_d_addr),
		.i_wr_data (i_wr_data),
		.i_i_acc   (i_i_acc),
		.i_d_acc   (i_d_acc),
		.i_write   (i_d_write),
		.i_i_hit   (i_hit),
		.i_d_hit   (d_hit),
		.i_dirty   (dirty),
		.i_mem_rdy (mem_rdy),
		.i_d_tag   (d_tag),
		.i_d_line  (d_line),
		.i_m_line  (m_line),
		.o_i_we    (i_we),
		.o_i_data  (i_data),
		.o_d_we    (d_we),
		.o_d_data  (d_data),
		.o_d_dirty (d_dirt_in),
		.o_m_re    (m_re),
		.o_m_we    (m_we),
		.o_m_addr  (m_addr),
		.o_m_data  (m_data),
		.o_rdy     (o_rdy)
	);

	dcache u_dcache (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_addr  (i_d_addr),
		.i_we    (d_we),
		.i_data  (d_data),
		.i_dirty (d_dirt_in),
		.o_hit   (d_hit),
		.o_dirty (dirty),
		.o_tag   (d_tag),
		.o_line  (d_line),
		.o_word  (o_rd_data)
	);

	unified_mem #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_re   (m_re),
		.i_we   (m_we),
		.i_addr (m_addr),
		.i_data (m_data),
		.o_rdy  (mem_rdy),
		.o_line (m_line)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 5, // 10 ns period
	parameter int RST_CYCLES  = 3
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;                      // Reset from time zero
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);                    // Release between rising edges
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker import cache_pkg::*; #(
	parameter int MEM_LATENCY = 4
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              i_i_acc,
	input  wire [ADDR_W-1:0] i_i_addr,
	input  wire              i_d_acc,
	input  wire [ADDR_W-1:0] i_d_addr,
	input  wire              i_d_write,
	input  wire [WORD_W-1:0] i_wr_data,
	input  wire [WORD_W-1:0] i_instr,   // DUT fetch word
	input  wire [WORD_W-1:0] i_rd_data, // DUT data word
	input  wire              i_rdy,
	input  wire [31:0]       i_test,    // Number of the running test
	input  wire              i_end,     // Stimulus is done
	output logic [31:0]      o_errors,
	output logic             o_closed   // Summary has been printed
);

	logic [LINE_W-1:0]     mem_m  [2**MEM_ADDR_W]; // Backing memory model
	logic [LINE_W-1:0]     d_line [2**INDEX_W];
	logic [TAG_W-1:0]      d_tag  [2**INDEX_W];
	logic [LINE_W-1:0]     i_line [2**INDEX_W];
	logic [TAG_W-1:0]      i_tag  [2**INDEX_W];
	logic [2**INDEX_W-1:0] d_valid;
	logic [2**INDEX_W-1:0] d_dirty;
	logic [2**INDEX_W-1:0] i_valid;
	int                    cur_test;    // Test whose results are being gathered
	int                    checks;
	int                    errs;
	int                    all_checks;
	int                    tests_run;
	int                    tests_bad;
	int                    wait_cycles; // Rising edges with a request pending and o_rdy low

	initial begin
		for (int a = 0; a < 2**MEM_ADDR_W; a++) begin
			mem_m[a] = '0; // Memory starts cleared
		end
		cur_test    = 0;
		checks      = 0;
		errs        = 0;
		all_checks  = 0;
		tests_run   = 0;
		tests_bad   = 0;
		wait_cycles = 0;
		o_errors    = '0;
		o_closed    = 1'b0;
	end

	function automatic string test_name(input int id);
		case (id)
			1:       return "clean_miss_hit";
			2:       return "write_hit";
			3:       return "write_miss";
			4:       return "dirty_evict";
			5:       return "ifetch_rules";
			6:       return "dual_miss";
			7:       return "random_mix";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errs++;
			$display("[ERROR] %s %s expected 0x%0h actual 0x%0h",
				test_name(cur_test), what, exp, act);
		end
	endtask

	task automatic close_test();
		tests_run++;
		all_checks += checks;
		o_errors   += errs;
		if (errs != 0) begin
			tests_bad++;
		end
		$display("%-15s %s  %0d checks, %0d errors", test_name(cur_test),
			(errs == 0) ? "passed" : "failed", checks, errs);
		checks = 0;
		errs   = 0;
	endtask

	// Model one accepted access, data side before the fetch side
	task automatic apply_access();
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  idx;
		logic [OFFSET_W-1:0] off;
		logic [LINE_W-1:0]   line;
		int                  services; // Memory transactions this access needed
		services = 0;
		if (i_d_acc) begin
			{tag, idx, off} = i_d_addr;
			if (!d_valid[idx] || d_tag[idx] != tag) begin
				if (d_valid[idx] && d_dirty[idx]) begin
					mem_m[{d_tag[idx], idx}] = d_line[idx]; // Victim goes out first
					services++;
				end
				d_line[idx]  = mem_m[{tag, idx}];
				d_tag[idx]   = tag;
				d_valid[idx] = 1'b1;
				d_dirty[idx] = 1'b0;
				services++;
			end
			line = d_line[idx];
			if (i_d_write) begin
				line[off*WORD_W +: WORD_W] = i_wr_data; // Only the addressed word moves
				d_line[idx]  = line;
				d_dirty[idx] = 1'b1;
			end else begin
				compare("rd_data", line[off*WORD_W +: WORD_W], i_rd_data);
			end
		end
		if (i_i_acc) begin
			{tag, idx, off} = i_i_addr;
			if (!i_valid[idx] || i_tag[idx] != tag) begin
				i_line[idx]  = mem_m[{tag, idx}]; // Stale data stays until refetched
				i_tag[idx]   = tag;
				i_valid[idx] = 1'b1;
				services++;
			end
			line = i_line[idx];
			compare("instr", line[off*WORD_W +: WORD_W], i_instr);
		end
		compare("latency", services * (MEM_LATENCY + 1), wait_cycles); // Miss cost each
		wait_cycles = 0;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			d_valid     = '0;
			d_dirty     = '0;
			i_valid     = '0;
			wait_cycles = 0;
		end else begin
			if (i_test != cur_test) begin
				if (cur_test != 0) begin
					close_test();
				end
				cur_test = i_test;
			end
			if (i_end && !o_closed) begin
				close_test();
				$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
					tests_run, tests_bad, all_checks, o_errors);
				o_closed = 1'b1;
			end
			if ((i_i_acc || i_d_acc) && i_rdy) begin
				apply_access();
			end else if (i_i_acc || i_d_acc) begin
				wait_cycles++;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_mem_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hierarchy;

	localparam int MEM_LATENCY = 4;
	localparam int TIMEOUT     = 200; // Cycles allowed for any wait

	logic        clk;
	logic        rst_n;
	logic        i_i_acc;
	logic        i_d_acc;
	logic        i_d_write;
	logic [15:0] i_i_addr;
	logic [15:0] i_d_addr;
	logic [15:0] i_wr_data;
	logic [15:0] o_instr;
	logic [15:0] o_rd_data;
	logic        o_rdy;
	logic [31:0] test_id;      // Current test as read by the checker
	logic        run_end;
	logic [31:0] errors;
	logic        closed;
	integer      seed;
	logic [7:0]  tag_pool [4]; // Few tags and indices keep conflicts frequent
	logic [5:0]  idx_pool [4];

	tb_clock u_clock (.o_clk(clk), .o_rst_n(rst_n));

	mem_hierarchy #(.MEM_LATENCY(MEM_LATENCY)) uut (.*);

	mem_checker #(.MEM_LATENCY(MEM_LATENCY)) u_checker (
		.*,
		.i_instr   (o_instr),
		.i_rd_data (o_rd_data),
		.i_rdy     (o_rdy),
		.i_test    (test_id),
		.i_end     (run_end),
		.o_errors  (errors),
		.o_closed  (closed)
	);

	task automatic give_up(input string what);
		$display("Run aborted in test %0d: %s", test_id, what);
		$display("TEST FAILED");
		$finish;
	endtask

	// Drive at the falling edge and hold until o_rdy is seen at a rising edge
	task automatic access(input logic ia, input logic [15:0] iaddr, input logic da,
		input logic [15:0] daddr, input logic wr, input logic [15:0] wdata);
		int cycles;
		@(negedge clk);
		i_i_acc   = ia;
		i_i_addr  = iaddr;
		i_d_acc   = da;
		i_d_addr  = daddr;
		i_d_write = wr;
		i_wr_data = wdata;
		cycles    = 0;
		@(posedge clk);
		while (!o_rdy && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!o_rdy) begin
			give_up("o_rdy stayed low for 200 cycles");
		end
	endtask

	task automatic dread(input logic [15:0] a);
		access(1'b0, 16'h0, 1'b1, a, 1'b0, 16'h0);
	endtask

	task automatic dwrite(input logic [15:0] a, input logic [15:0] d);
		access(1'b0, 16'h0, 1'b1, a, 1'b1, d);
	endtask

	task automatic fetch(input logic [15:0] a);
		access(1'b1, a, 1'b0, 16'h0, 1'b0, 16'h0);
	endtask

	// Requests drop before the checker moves to the next test
	task automatic start_test(input int id);
		@(negedge clk);
		i_i_acc = 1'b0;
		i_d_acc = 1'b0;
		test_id = id;
	endtask

	task automatic finish_run();
		int cycles;
		@(negedge clk);
		i_i_acc = 1'b0;
		i_d_acc = 1'b0;
		run_end = 1'b1;
		cycles  = 0;
		while (!closed && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!closed) begin
			give_up("checker summary never arrived");
		end else if (errors == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("TEST FAILED");
			$finish;
		end
	endtask

	initial begin
		int          n;
		int          cycles;
		logic [31:0] r;
		i_i_acc   = 1'b0;
		i_d_acc   = 1'b0;
		i_d_write = 1'b0;
		i_i_addr  = '0;
		i_d_addr  = '0;
		i_wr_data = '0;
		test_id   = 0;
		run_end   = 1'b0;
		seed      = 32'h991c;
		tag_pool  = '{8'h00, 8'h01, 8'h80, 8'hff};
		idx_pool  = '{6'd0, 6'd1, 6'd33, 6'd63};
		cycles    = 0;
		while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			give_up("reset was never released");
		end
		start_test(1);
		dread({8'h12, 6'd3, 2'd1});           // Clean miss
		dread({8'h12, 6'd3, 2'd1});           // Same word again is now a hit
		start_test(2);
		dread({8'h12, 6'd4, 2'd0});           // Make the line resident
		dwrite({8'h12, 6'd4, 2'd2}, 16'hbeef);
		dwrite({8'h12, 6'd4, 2'd0}, 16'h1234); // Second store keeps the first one
		for (n = 0; n < 4; n++) begin
			dread({8'h12, 6'd4, n[1:0]});
		end
		start_test(3);
		dread({8'h34, 6'd4, 2'd0});           // Dirty line goes back to memory
		dwrite({8'h12, 6'd4, 2'd1}, 16'h5a5a); // Allocate on store over nonzero memory
		for (n = 0; n < 4; n++) begin
			dread({8'h12, 6'd4, n[1:0]});
		end
		start_test(4);
		dwrite({8'h10, 6'd9, 2'd3}, 16'hc0de);
		dread({8'h20, 6'd9, 2'd0});           // Same index pushes the dirty line out
		dread({8'h10, 6'd9, 2'd3});
		start_test(5);
		fetch({8'h30, 6'd12, 2'd0});          // Fill before the store
		dwrite({8'h30, 6'd12, 2'd0}, 16'h1111);
		dread({8'h31, 6'd12, 2'd0});          // Store reaches memory
		fetch({8'h30, 6'd12, 2'd0});          // Old contents still cached
		fetch({8'h32, 6'd12, 2'd0});          // Conflicting fetch evicts it
		fetch({8'h30, 6'd12, 2'd0});
		start_test(6);
		access(1'b1, {8'h40, 6'd20, 2'd1}, 1'b1, {8'h41, 6'd21, 2'd2}, 1'b0, 16'h0);
		dwrite({8'h42, 6'd22, 2'd0}, 16'h7777);
		access(1'b1, {8'h42, 6'd22, 2'd0}, 1'b1, {8'h43, 6'd22, 2'd0}, 1'b0, 16'h0);
		start_test(7);
		for (n = 0; n < 400; n++) begin
			r = $random(seed); // Port mix, pool picks and store data from one draw
			access(r[1:0] != 2'd1, {tag_pool[r[4:3]], idx_pool[r[6:5]], r[8:7]},
				r[1:0] != 2'd0, {tag_pool[r[10:9]], idx_pool[r[12:11]], r[14:13]},
				r[2], r[31:16]);
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/cache_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/cache_controller.sv
rtl/unified_mem.sv
rtl/mem_hierarchy.sv
testbench/tb_clock.sv
testbench/mem_checker.sv
testbench/tb_mem_hierarchy.sv
